//--- src/proxy_defs.svh
// field widths, lane depth and the host's own coordinate and channel.
`ifndef PROXY_DEFS_SVH
`define PROXY_DEFS_SVH

// routing header field widths.
`define PROXY_DID_W  4
`define PROXY_CORD_W 6
`define PROXY_CID_W  2

// payload field widths.
`define PROXY_ADDR_W 32
`define PROXY_DATA_W 32

// entries held by each path lane.
`define PROXY_LANE_DEPTH 2

// where off-chip commands land on the memory network.
`define PROXY_HOST_CORD 6'd5
`define PROXY_HOST_CID  2'd1

`endif

//--- src/proxy_pkg.sv
// message kind and lane enums, routing header and payload structs.
`include "proxy_defs.svh"

package proxy_pkg;

  // kind bit carried in every routing header.
  typedef enum logic
  {
    MSG_CMD  = 1'b0,
    MSG_RESP = 1'b1
  } msg_kind_e;

  // one lane per direction and kind.
  // the value doubles as the lane index in the top level.
  typedef enum logic [1:0]
  {
    LANE_ON_OFF_CMD  = 2'd0,
    LANE_ON_OFF_RESP = 2'd1,
    LANE_OFF_ON_CMD  = 2'd2,
    LANE_OFF_ON_RESP = 2'd3
  } lane_e;

  // header used by the network to route the flit.
  typedef struct packed
  {
    logic [`PROXY_DID_W-1:0]  did;
    logic [`PROXY_CORD_W-1:0] cord;
    logic [`PROXY_CID_W-1:0]  cid;
    msg_kind_e                kind;
  } route_hdr_s;

  // the sender's return address travels with the message body.
  typedef struct packed
  {
    logic [`PROXY_DID_W-1:0]  src_did;
    logic [`PROXY_CORD_W-1:0] src_cord;
    logic [`PROXY_CID_W-1:0]  src_cid;
    logic [`PROXY_ADDR_W-1:0] addr;
    logic [`PROXY_DATA_W-1:0] data;
  } msg_payload_s;

endpackage

//--- src/proxy_msg_if.sv
// single-flit message link with valid/ready handshake.
`timescale 1ns/100ps

interface proxy_msg_if;

  logic                     v;
  logic                     ready;
  proxy_pkg::route_hdr_s    hdr;
  proxy_pkg::msg_payload_s  payload;

  // the sender holds hdr and payload steady from v until the transfer.
  modport tx
  (
    output v,
    output hdr,
    output payload,
    input  ready
  );

  modport rx
  (
    input  v,
    input  hdr,
    input  payload,
    output ready
  );

endinterface

//--- src/proxy_ingress.sv
// steering of the on-chip and off-chip input links into the four lanes.
`timescale 1ns/100ps

module proxy_ingress
  (
  input  logic                     on_v_i,
  input  proxy_pkg::route_hdr_s    on_hdr_i,
  input  proxy_pkg::msg_payload_s  on_payload_i,
  output logic                     on_ready_o,

  input  logic                     off_v_i,
  input  proxy_pkg::route_hdr_s    off_hdr_i,
  input  proxy_pkg::msg_payload_s  off_payload_i,
  output logic                     off_ready_o,

  proxy_msg_if.tx                  lane_in [4]
  );

  logic on_is_cmd;
  logic off_is_cmd;

  assign on_is_cmd  = (on_hdr_i.kind == proxy_pkg::MSG_CMD);
  assign off_is_cmd = (off_hdr_i.kind == proxy_pkg::MSG_CMD);

  // on-chip traffic feeds lanes 0 and 1.
  assign lane_in[0].v       = on_v_i & on_is_cmd;
  assign lane_in[0].hdr     = on_hdr_i;
  assign lane_in[0].payload = on_payload_i;

  assign lane_in[1].v       = on_v_i & ~on_is_cmd;
  assign lane_in[1].hdr     = on_hdr_i;
  assign lane_in[1].payload = on_payload_i;

  // off-chip traffic feeds lanes 2 and 3.
  assign lane_in[2].v       = off_v_i & off_is_cmd;
  assign lane_in[2].hdr     = off_hdr_i;
  assign lane_in[2].payload = off_payload_i;

  assign lane_in[3].v       = off_v_i & ~off_is_cmd;
  assign lane_in[3].hdr     = off_hdr_i;
  assign lane_in[3].payload = off_payload_i;

  // each link only waits on the lane its current message is headed for.
  always_comb
  begin
    if (on_is_cmd)
      on_ready_o = lane_in[0].ready;
    else
      on_ready_o = lane_in[1].ready;

    if (off_is_cmd)
      off_ready_o = lane_in[2].ready;
    else
      off_ready_o = lane_in[3].ready;
  end

endmodule

//--- src/proxy_lane.sv
// path lane: small message queue that rewrites the routing header on enqueue.
`timescale 1ns/100ps
`include "proxy_defs.svh"

module proxy_lane
  #(
  parameter proxy_pkg::lane_e lane_p = proxy_pkg::LANE_ON_OFF_CMD
  )
  (
  input  logic     clk_i,
  input  logic     reset_i,
  proxy_msg_if.rx  in,
  proxy_msg_if.tx  out
  );

  localparam int ptr_w = $clog2(`PROXY_LANE_DEPTH);
  localparam int cnt_w = $clog2(`PROXY_LANE_DEPTH + 1);
  localparam int pad_w = `PROXY_CORD_W - `PROXY_DID_W;
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`PROXY_LANE_DEPTH);

  proxy_pkg::route_hdr_s   hdr_mem [`PROXY_LANE_DEPTH];
  proxy_pkg::msg_payload_s payload_mem [`PROXY_LANE_DEPTH];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             push;
  logic             pop;
  proxy_pkg::route_hdr_s hdr_rw;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(`PROXY_LANE_DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // header rewrite for this lane's path; the kind bit passes through.
  always_comb
  begin
    hdr_rw = in.hdr;
    case (lane_p)
      proxy_pkg::LANE_ON_OFF_CMD:
      begin
        // the inter-domain network routes on domain, so aim at it.
        hdr_rw.cord = {{pad_w{1'b0}}, in.hdr.did};
        hdr_rw.cid  = '0;
      end
      proxy_pkg::LANE_ON_OFF_RESP:
      begin
        hdr_rw.did  = in.payload.src_did;
        hdr_rw.cord = {{pad_w{1'b0}}, in.payload.src_did};
        hdr_rw.cid  = '0;
      end
      proxy_pkg::LANE_OFF_ON_CMD:
      begin
        hdr_rw.cord = `PROXY_HOST_CORD;
        hdr_rw.cid  = `PROXY_HOST_CID;
      end
      proxy_pkg::LANE_OFF_ON_RESP:
      begin
        // send the response back to whoever issued the command.
        hdr_rw.did  = in.payload.src_did;
        hdr_rw.cord = in.payload.src_cord;
        hdr_rw.cid  = in.payload.src_cid;
      end
    endcase
  end

  assign in.ready    = (count_q != full_cnt);
  assign out.v       = (count_q != '0);
  assign out.hdr     = hdr_mem[rd_ptr_q];
  assign out.payload = payload_mem[rd_ptr_q];

  assign push = in.v & in.ready;
  assign pop  = out.v & out.ready;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      hdr_mem[wr_ptr_q]     <= hdr_rw;
      payload_mem[wr_ptr_q] <= in.payload;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

endmodule

//--- src/proxy_egress.sv
// round-robin merge of command and response lanes onto each output link.
`timescale 1ns/100ps

module proxy_egress
  (
  input  logic                     clk_i,
  input  logic                     reset_i,

  proxy_msg_if.rx                  lane_out [4],

  input  logic                     on_ready_i,
  output logic                     on_v_o,
  output proxy_pkg::route_hdr_s    on_hdr_o,
  output proxy_pkg::msg_payload_s  on_payload_o,

  input  logic                     off_ready_i,
  output logic                     off_v_o,
  output proxy_pkg::route_hdr_s    off_hdr_o,
  output proxy_pkg::msg_payload_s  off_payload_o
  );

  // link 0 is off-chip and drains lanes 0 and 1, link 1 is on-chip with lanes 2 and 3.
  logic [1:0]              link_ready;
  logic [1:0]              link_v;
  proxy_pkg::route_hdr_s   link_hdr [2];
  proxy_pkg::msg_payload_s link_payload [2];

  assign link_ready = {on_ready_i, off_ready_i};

  for (genvar g = 0; g < 2; g++)
  begin : g_link
    logic cmd_v;
    logic resp_v;
    logic arb_gnt;
    logic gnt;
    logic rr_q;
    logic lock_q;
    logic lock_gnt_q;
    logic xfer;

    assign cmd_v  = lane_out[2*g].v;
    assign resp_v = lane_out[2*g+1].v;

    // rr_q names the lane favoured on a tie; 0 is the command lane.
    always_comb
    begin
      if (cmd_v && resp_v)
        arb_gnt = rr_q;
      else
        arb_gnt = resp_v;
    end

    // a stalled offer keeps its lane so the output stays stable.
    assign gnt  = lock_q ? lock_gnt_q : arb_gnt;
    assign xfer = link_v[g] & link_ready[g];

    assign link_v[g]       = cmd_v | resp_v;
    assign link_hdr[g]     = gnt ? lane_out[2*g+1].hdr : lane_out[2*g].hdr;
    assign link_payload[g] = gnt ? lane_out[2*g+1].payload : lane_out[2*g].payload;

    assign lane_out[2*g].ready   = link_ready[g] & ~gnt;
    assign lane_out[2*g+1].ready = link_ready[g] & gnt;

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        rr_q       <= 1'b0;
        lock_q     <= 1'b0;
        lock_gnt_q <= 1'b0;
      end
      else
      begin
        if (xfer)
          rr_q <= ~gnt;
        lock_q     <= link_v[g] & ~link_ready[g];
        lock_gnt_q <= gnt;
      end
    end
  end

  assign off_v_o       = link_v[0];
  assign off_hdr_o     = link_hdr[0];
  assign off_payload_o = link_payload[0];

  assign on_v_o        = link_v[1];
  assign on_hdr_o      = link_hdr[1];
  assign on_payload_o  = link_payload[1];

endmodule

//--- src/host_proxy_top.sv
// host proxy between the on-chip memory network and the off-chip network.
`timescale 1ns/100ps

module host_proxy_top
  (
  input  logic                     clk_i,
  input  logic                     reset_i,

  // on-chip input link.
  input  logic                     on_v_i,
  input  proxy_pkg::route_hdr_s    on_hdr_i,
  input  proxy_pkg::msg_payload_s  on_payload_i,
  output logic                     on_ready_o,

  // off-chip input link.
  input  logic                     off_v_i,
  input  proxy_pkg::route_hdr_s    off_hdr_i,
  input  proxy_pkg::msg_payload_s  off_payload_i,
  output logic                     off_ready_o,

  // on-chip output link.
  output logic                     on_v_o,
  output proxy_pkg::route_hdr_s    on_hdr_o,
  output proxy_pkg::msg_payload_s  on_payload_o,
  input  logic                     on_ready_i,

  // off-chip output link.
  output logic                     off_v_o,
  output proxy_pkg::route_hdr_s    off_hdr_o,
  output proxy_pkg::msg_payload_s  off_payload_o,
  input  logic                     off_ready_i
  );

  proxy_msg_if lane_in [4] ();
  proxy_msg_if lane_out [4] ();

  proxy_ingress u_ingress
  (
    .on_v_i        (on_v_i),
    .on_hdr_i      (on_hdr_i),
    .on_payload_i  (on_payload_i),
    .on_ready_o    (on_ready_o),
    .off_v_i       (off_v_i),
    .off_hdr_i     (off_hdr_i),
    .off_payload_i (off_payload_i),
    .off_ready_o   (off_ready_o),
    .lane_in       (lane_in)
  );

  // lane index matches the lane_e value of its path.
  for (genvar i = 0; i < 4; i++)
  begin : g_lane
    proxy_lane
    #(
      .lane_p (proxy_pkg::lane_e'(i))
    )
    u_lane
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .in      (lane_in[i]),
      .out     (lane_out[i])
    );
  end

  proxy_egress u_egress
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lane_out      (lane_out),
    .on_ready_i    (on_ready_i),
    .on_v_o        (on_v_o),
    .on_hdr_o      (on_hdr_o),
    .on_payload_o  (on_payload_o),
    .off_ready_i   (off_ready_i),
    .off_v_o       (off_v_o),
    .off_hdr_o     (off_hdr_o),
    .off_payload_o (off_payload_o)
  );

endmodule

//--- tests/host_proxy_assert.sv
// handshake assertions on both output links, bound to the proxy top level.
`timescale 1ns/100ps

module host_proxy_assert
  (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    on_v_o,
  input logic                    on_ready_i,
  input proxy_pkg::route_hdr_s   on_hdr_o,
  input proxy_pkg::msg_payload_s on_payload_o,
  input logic                    off_v_o,
  input logic                    off_ready_i,
  input proxy_pkg::route_hdr_s   off_hdr_o,
  input proxy_pkg::msg_payload_s off_payload_o
  );

  int fail_count = 0;

  // every reset edge leaves both outputs idle.
  a_reset_idle : assert property (@(posedge clk_i) reset_i |=> !on_v_o && !off_v_o)
  else
  begin
    fail_count++;
    $error("output valid high after a reset cycle");
  end

  a_on_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    on_v_o && !on_ready_i |=> $stable(on_hdr_o) && $stable(on_payload_o))
  else
  begin
    fail_count++;
    $error("on-chip output changed while stalled");
  end

  a_off_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    off_v_o && !off_ready_i |=> $stable(off_hdr_o) && $stable(off_payload_o))
  else
  begin
    fail_count++;
    $error("off-chip output changed while stalled");
  end

  a_on_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    on_v_o && !on_ready_i |=> on_v_o)
  else
  begin
    fail_count++;
    $error("on-chip output valid dropped without a transfer");
  end

  a_off_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    off_v_o && !off_ready_i |=> off_v_o)
  else
  begin
    fail_count++;
    $error("off-chip output valid dropped without a transfer");
  end

endmodule

bind host_proxy_top host_proxy_assert u_assert (.*);

//--- tests/host_proxy_tb.sv
// testbench for the host proxy: golden-file stimulus, random back-pressure,
// per-lane scoreboard and report.
`timescale 1ns/100ps
`include "proxy_defs.svh"

module host_proxy_tb;

  typedef struct packed
  {
    logic [7:0]              idx;
    proxy_pkg::route_hdr_s   hdr;
    proxy_pkg::msg_payload_s payload;
  } exp_s;

  localparam int max_rec = 64;
  localparam int mode_random = 0;
  localparam int mode_high = 1;
  localparam int mode_off_stall = 2;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic                    on_v_i;
  proxy_pkg::route_hdr_s   on_hdr_i;
  proxy_pkg::msg_payload_s on_payload_i;
  logic                    on_ready_o;
  logic                    off_v_i;
  proxy_pkg::route_hdr_s   off_hdr_i;
  proxy_pkg::msg_payload_s off_payload_i;
  logic                    off_ready_o;
  logic                    on_v_o;
  proxy_pkg::route_hdr_s   on_hdr_o;
  proxy_pkg::msg_payload_s on_payload_o;
  logic                    on_ready_i;
  logic                    off_v_o;
  proxy_pkg::route_hdr_s   off_hdr_o;
  proxy_pkg::msg_payload_s off_payload_o;
  logic                    off_ready_i;

  // records from the golden file, in file order.
  string                   name_mem [max_rec];
  bit                      link_mem [max_rec];
  proxy_pkg::route_hdr_s   in_hdr_mem [max_rec];
  proxy_pkg::msg_payload_s in_pay_mem [max_rec];
  proxy_pkg::route_hdr_s   exp_hdr_mem [max_rec];

  // queue index is {output is on-chip, kind}, which is also the lane index.
  exp_s        exp_q [4][$];
  int          order_kinds [$];
  int          lane_cnt [4] = '{0, 0, 0, 0};
  int          num_rec = 0;
  int          errors = 0;
  int          group_errors = 0;
  int          tests = 0;
  int          messages = 0;
  int          outstanding = 0;
  int          ready_mode = mode_high;
  bit          loaded = 1'b0;
  bit          order_check = 1'b0;
  logic [31:0] rng = 32'd21;
  string       cur_group = "reset";

  host_proxy_top u_dut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic count_error();
    errors++;
    group_errors++;
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    string       nm;
    string       link;
    logic [31:0] f [13];
    fd = $fopen("tests/host_proxy_golden.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd) && num_rec < max_rec)
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 0) != "#")
        begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h", nm, link,
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                      f[11], f[12]);
          if (n == 15)
          begin
            name_mem[num_rec]    = nm;
            link_mem[num_rec]    = (link == "off");
            in_hdr_mem[num_rec]  = {f[0][`PROXY_DID_W-1:0], f[1][`PROXY_CORD_W-1:0],
                                    f[2][`PROXY_CID_W-1:0], f[3][0]};
            in_pay_mem[num_rec]  = {f[4][`PROXY_DID_W-1:0], f[5][`PROXY_CORD_W-1:0],
                                    f[6][`PROXY_CID_W-1:0], f[7][`PROXY_ADDR_W-1:0],
                                    f[8][`PROXY_DATA_W-1:0]};
            exp_hdr_mem[num_rec] = {f[9][`PROXY_DID_W-1:0], f[10][`PROXY_CORD_W-1:0],
                                    f[11][`PROXY_CID_W-1:0], f[12][0]};
            num_rec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_in_ready(input int lane, input logic ready);
    if (ready && lane_cnt[lane] >= `PROXY_LANE_DEPTH)
    begin
      $display("test %s: input ready high while lane %0d was full", cur_group, lane);
      count_error();
    end
    if (!ready && lane_cnt[lane] < `PROXY_LANE_DEPTH)
    begin
      $display("test %s: input ready low while lane %0d had room", cur_group, lane);
      count_error();
    end
  endtask

  task automatic check_output(input int q, input proxy_pkg::route_hdr_s hdr,
                              input proxy_pkg::msg_payload_s pay);
    exp_s e;
    int   k;
    if (exp_q[q].size() == 0)
    begin
      $display("test %s: unexpected message with header %h from lane %0d", cur_group, hdr, q);
      count_error();
    end
    else
    begin
      e = exp_q[q].pop_front();
      outstanding--;
      messages++;
      if (hdr !== e.hdr || pay !== e.payload)
      begin
        $display("Mismatch %s: expected %h %h, actual %h %h", name_mem[e.idx], e.hdr,
                 e.payload, hdr, pay);
        count_error();
      end
    end
    if (order_check && q < 2 && order_kinds.size() > 0)
    begin
      k = order_kinds.pop_front();
      if (k != int'(hdr.kind))
      begin
        $display("Mismatch %s: expected kind %0d, actual kind %0d", cur_group, k, hdr.kind);
        count_error();
      end
    end
  endtask

  // checks use the lane counts from before this edge, then the counts follow the transfers.
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (on_v_i)
        check_in_ready({1'b0, on_hdr_i.kind}, on_ready_o);
      if (off_v_i)
        check_in_ready({1'b1, off_hdr_i.kind}, off_ready_o);
      if (off_v_o && off_ready_i)
        check_output({1'b0, off_hdr_o.kind}, off_hdr_o, off_payload_o);
      if (on_v_o && on_ready_i)
        check_output({1'b1, on_hdr_o.kind}, on_hdr_o, on_payload_o);
      if (on_v_i && on_ready_o)
        lane_cnt[{1'b0, on_hdr_i.kind}]++;
      if (off_v_i && off_ready_o)
        lane_cnt[{1'b1, off_hdr_i.kind}]++;
      if (off_v_o && off_ready_i)
        lane_cnt[{1'b0, off_hdr_o.kind}]--;
      if (on_v_o && on_ready_i)
        lane_cnt[{1'b1, on_hdr_o.kind}]--;
    end
  end

  always @(negedge clk_i)
  begin
    if (ready_mode == mode_random)
    begin
      rng = xorshift32(rng);
      on_ready_i  = rng[4];
      off_ready_i = rng[11];
    end
    else
    begin
      on_ready_i  = 1'b1;
      off_ready_i = (ready_mode != mode_off_stall);
    end
  end

  task automatic send_msg(input bit off_link, input int k);
    @(negedge clk_i);
    if (off_link)
    begin
      off_v_i       = 1'b1;
      off_hdr_i     = in_hdr_mem[k];
      off_payload_i = in_pay_mem[k];
    end
    else
    begin
      on_v_i       = 1'b1;
      on_hdr_i     = in_hdr_mem[k];
      on_payload_i = in_pay_mem[k];
    end
    @(posedge clk_i);
    while (!(off_link ? off_ready_o : on_ready_o))
      @(posedge clk_i);
  endtask

  task automatic drive_link(input bit off_link, input int first, input int last);
    int k;
    bit sent;
    sent = 1'b0;
    for (k = first; k < last; k++)
    begin
      if (link_mem[k] == off_link)
      begin
        send_msg(off_link, k);
        sent = 1'b1;
      end
    end
    if (sent)
    begin
      @(negedge clk_i);
      if (off_link)
        off_v_i = 1'b0;
      else
        on_v_i = 1'b0;
    end
  endtask

  task automatic check_reset();
    int k;
    for (k = 0; k < 13; k++)
    begin
      @(negedge clk_i);
      if (on_v_o !== 1'b0 || off_v_o !== 1'b0)
      begin
        $display("test reset: output valid high at cycle %0d with no input valid", k);
        count_error();
      end
      if (k == 9)
        reset_i = 1'b0;
    end
    tests++;
    $display("test reset: 0 messages, %0d errors", group_errors);
  endtask

  // the fairness group fills lanes 0 and 1 behind a stalled off-chip output first.
  task automatic run_group(input int first, input int last);
    int k;
    cur_group    = name_mem[first];
    group_errors = 0;
    outstanding  = last - first;
    order_check  = (cur_group == "fairness");
    for (k = first; k < last; k++)
    begin
      exp_q[{link_mem[k], exp_hdr_mem[k].kind}].push_back({8'(k), exp_hdr_mem[k],
                                                           in_pay_mem[k]});
      if (order_check && !link_mem[k])
        order_kinds.push_back(int'(exp_hdr_mem[k].kind));
    end
    ready_mode = order_check ? mode_off_stall : mode_random;
    fork
      drive_link(1'b0, first, last);
      drive_link(1'b1, first, last);
    join
    if (order_check)
    begin
      @(posedge clk_i);
      ready_mode = mode_high;
    end
    wait (outstanding == 0);
    order_check = 1'b0;
    tests++;
    $display("test %s: %0d messages, %0d errors", cur_group, last - first, group_errors);
  endtask

  initial
  begin
    int first;
    int last;
    reset_i       = 1'b1;
    on_v_i        = 1'b0;
    on_hdr_i      = '0;
    on_payload_i  = '0;
    off_v_i       = 1'b0;
    off_hdr_i     = '0;
    off_payload_i = '0;
    on_ready_i    = 1'b1;
    off_ready_i   = 1'b1;
    load_golden();
    check_reset();
    if (num_rec == 0)
    begin
      $display("could not read any message from tests/host_proxy_golden.txt");
      errors++;
    end
    else
    begin
      loaded = 1'b1;
      first = 0;
      while (first < num_rec)
      begin
        last = first + 1;
        while (last < num_rec && name_mem[last] == name_mem[first])
          last++;
        run_group(first, last);
        first = last;
      end
    end
    if (u_dut.u_assert.fail_count != 0)
    begin
      $display("%0d handshake assertions fired", u_dut.u_assert.fail_count);
      errors += u_dut.u_assert.fail_count;
    end
    $display("tests %0d, messages %0d, errors %0d", tests, messages, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    wait (loaded);
    repeat (num_rec * 40 + 200) @(posedge clk_i);
    $display("timeout: %0d messages of test %s never left the proxy", outstanding, cur_group);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- tests/host_proxy_golden.txt
# name link did cord cid kind src_did src_cord src_cid addr data exp_did exp_cord exp_cid exp_kind
# all fields are hex; link is the input link, the expected header leaves on the other link.
fairness     on  3 12 2 0  1 0a 3 00001000 a5a50001  3 03 0 0
fairness     on  7 21 1 1  2 1b 2 00001004 a5a50002  2 02 0 1
fairness     on  9 05 3 0  4 07 1 00001008 a5a50003  9 09 0 0
fairness     on  4 3f 0 1  c 2e 0 0000100c a5a50004  c 0c 0 1
on_off       on  a 11 1 0  5 2c 3 00002000 0badf00d  a 0a 0 0
on_off       on  1 00 2 1  6 13 1 00002004 12345678  6 06 0 1
on_off       on  f 3a 3 0  0 01 2 00002008 ffffffff  f 0f 0 0
on_off       on  2 2b 0 1  f 3c 3 0000200c 00000000  f 0f 0 1
off_on       off 3 00 0 0  8 22 2 00003000 cafe0001  3 05 1 0
off_on       off 6 14 2 1  2 31 3 00003004 cafe0002  2 31 3 1
off_on       off 0 3f 3 0  b 0e 0 00003008 cafe0003  0 05 1 0
off_on       off 9 07 1 1  d 19 1 0000300c cafe0004  d 19 1 1
concurrent   on  5 01 1 0  3 09 0 00004000 11110001  5 05 0 0
concurrent   off 4 02 0 0  7 0c 3 00004004 22220001  4 05 1 0
concurrent   on  8 2a 2 1  e 10 1 00004008 11110002  e 0e 0 1
concurrent   off 1 33 3 1  a 2f 2 0000400c 22220002  a 2f 2 1
concurrent   on  6 18 3 0  1 3d 2 00004010 11110003  6 06 0 0
concurrent   off c 0b 2 1  4 06 1 00004014 22220003  4 06 1 1
backpressure on  1 01 0 0  2 03 1 00005000 33330001  1 01 0 0
backpressure on  2 02 1 0  3 04 2 00005004 33330002  2 02 0 0
backpressure on  3 03 2 1  4 05 3 00005008 33330003  4 04 0 1
backpressure on  4 04 3 0  5 06 0 0000500c 33330004  4 04 0 0
backpressure on  5 05 0 1  6 07 1 00005010 33330005  6 06 0 1
backpressure off 6 06 1 0  7 08 2 00005014 44440001  6 05 1 0
backpressure off 7 07 2 1  8 09 3 00005018 44440002  8 09 3 1
backpressure off 8 08 3 0  9 0a 0 0000501c 44440003  8 05 1 0
backpressure off 9 09 0 1  a 0b 1 00005020 44440004  a 0b 1 1
backpressure off a 0a 1 1  b 0c 2 00005024 44440005  b 0c 2 1

//--- sim.f
+incdir+src
src/proxy_pkg.sv
src/proxy_msg_if.sv
src/proxy_ingress.sv
src/proxy_lane.sv
src/proxy_egress.sv
src/host_proxy_top.sv
tests/host_proxy_assert.sv
tests/host_proxy_tb.sv

//--- Bender.yml
package:
  name: host_proxy

sources:
  - include_dirs:
      - src
    files:
      - src/proxy_pkg.sv
      - src/proxy_msg_if.sv
      - src/proxy_ingress.sv
      - src/proxy_lane.sv
      - src/proxy_egress.sv
      - src/host_proxy_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/host_proxy_assert.sv
      - tests/host_proxy_tb.sv
